// ==== rtl/dma_bus_pkg.sv ====
// bus-side definitions for the CPCI DMA port; compiled ahead of every module that imports them
`default_nettype none

package dma_bus_pkg;

	localparam int DMA_DATA_WIDTH = 32; // bus data word, also queue payload

	// opcodes seen on dma_op_code_req and echoed on dma_op_code_ack
	typedef enum logic [1:0] {
		OP_IDLE         = 2'b00,
		OP_STATUS_QUERY = 2'b01,
		OP_TRANSF_C2N   = 2'b10, // host to card
		OP_TRANSF_N2C   = 2'b11  // card to host
	} dma_op_e;

	// bus FSM states
	typedef enum logic [3:0] {
		ST_IDLE     = 4'h0,
		ST_QUERY    = 4'h1,
		ST_C2N_QID  = 4'h2, // issue tx request word
		ST_C2N_LEN  = 4'h3,
		ST_C2N_DATA = 4'h4,
		ST_C2N_DONE = 4'h5,
		ST_N2C_QID  = 4'h6, // issue rx request word
		ST_N2C_LEN  = 4'h7,
		ST_N2C_DATA = 4'h8,
		ST_N2C_DONE = 4'h9
	} dma_bus_state_e;

endpackage

`default_nettype wire

// ==== rtl/dma_queue_pkg.sv ====
// queue-side word formats between the bus FSM and the CPU queues; compiled after dma_bus_pkg
`default_nettype none

package dma_queue_pkg;

	localparam int QID_WIDTH = 4; // queue id on the bus and in request words

	// transmit stream word, FSM to dispatcher
	typedef struct packed {
		logic                                   is_req;      // 1 request, 0 packet data
		logic                                   eop_or_dir;  // data: eop; request: 1 rx, 0 tx
		logic [1:0]                             valid_bytes; // 00 means 4 bytes
		logic [dma_bus_pkg::DMA_DATA_WIDTH-1:0] data;        // payload or zero-extended qid
	} dma_tx_word_t;

	// word as stored in a queue and returned on the receive stream
	typedef struct packed {
		logic                                   eop;
		logic [1:0]                             valid_bytes;
		logic [dma_bus_pkg::DMA_DATA_WIDTH-1:0] data;
	} dma_rx_word_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_queue.sv ====
// one CPU packet queue; circular word buffer with packet count and status flags
`timescale 1ns/1ps
`default_nettype none

module cpu_queue #(
	parameter int QUEUE_DEPTH      = 64,
	parameter int NEARLY_FULL_FREE = 16
) (
	input  wire logic                   cpci_clk,
	input  wire logic                   cpci_reset,
	input  wire logic                   wr,
	input  var  dma_queue_pkg::dma_rx_word_t wr_word,
	input  wire logic                   rd,
	output dma_queue_pkg::dma_rx_word_t rd_word, // head word, valid while not empty
	output logic                        empty,
	output logic                        pkt_avail,
	output logic                        nearly_full
);
	import dma_queue_pkg::*;

	localparam int AW = $clog2(QUEUE_DEPTH);
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam logic [AW-1:0] LAST_ADDR = AW'(QUEUE_DEPTH - 1);
	localparam logic [CW-1:0] DEPTH_CNT = CW'(QUEUE_DEPTH);
	localparam logic [CW-1:0] NF_FREE   = CW'(NEARLY_FULL_FREE);

	dma_rx_word_t  mem [QUEUE_DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;   // words held
	logic [CW-1:0] pkt_cnt; // complete packets held
	logic          full;

	assign full        = count == DEPTH_CNT;
	assign empty       = count == '0;
	assign rd_word     = mem[rd_ptr];
	assign pkt_avail   = pkt_cnt != '0; // a zero-length packet counts too
	assign nearly_full = (DEPTH_CNT - count) <= NF_FREE;

	always_ff @(posedge cpci_clk) begin
		if (wr)
			mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			pkt_cnt <= '0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
			count   <= count + CW'(wr) - CW'(rd);
			// eop in, eop out
			pkt_cnt <= pkt_cnt + CW'(wr && wr_word.eop) - CW'(rd && rd_word.eop);
		end
	end

	a_no_overflow: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		wr |-> !full)
		else $error("write to full queue");

	a_no_underflow: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		rd |-> !empty)
		else $error("read from empty queue");

endmodule

`default_nettype wire

// ==== rtl/dma_tx_dispatch.sv ====
// transmit stream decoder; routes c2n words to the latched queue and passes rx requests on
`timescale 1ns/1ps
`default_nettype none

module dma_tx_dispatch #(
	parameter int NUM_CPU_QUEUES = 4
) (
	input  wire logic                                cpci_clk,
	input  wire logic                                cpci_reset,
	input  var  dma_queue_pkg::dma_tx_word_t         tx_word,
	input  wire logic                                tx_wr,
	output logic [NUM_CPU_QUEUES-1:0]                q_wr,
	output dma_queue_pkg::dma_rx_word_t              q_wr_word, // shared by all queues
	input  wire logic [NUM_CPU_QUEUES-1:0]           q_nearly_full,
	output logic                                     tx_nearly_full,
	output logic                                     rx_sel_valid,
	output logic [dma_queue_pkg::QID_WIDTH-1:0]      rx_sel_qid
);
	import dma_queue_pkg::*;

	localparam logic [NUM_CPU_QUEUES-1:0] Q0_BIT = 1;

	logic [QID_WIDTH-1:0]      tgt_qid;   // c2n target
	logic                      tgt_valid; // set by the first tx request
	logic [NUM_CPU_QUEUES-1:0] tgt_mask;
	logic                      data_wr;

	assign data_wr = tx_wr && !tx_word.is_req;

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			tgt_qid   <= '0;
			tgt_valid <= 1'b0;
		end else if (tx_wr && tx_word.is_req && !tx_word.eop_or_dir) begin
			tgt_qid   <= tx_word.data[QID_WIDTH-1:0];
			tgt_valid <= 1'b1;
		end
	end

	assign tgt_mask = tgt_valid ? (Q0_BIT << tgt_qid) : '0; // out-of-range id selects nothing

	assign q_wr      = data_wr ? tgt_mask : '0;
	assign q_wr_word = '{eop: tx_word.eop_or_dir, valid_bytes: tx_word.valid_bytes,
		data: tx_word.data};

	assign tx_nearly_full = |(q_nearly_full & tgt_mask);

	// rx request goes straight to the collector
	assign rx_sel_valid = tx_wr && tx_word.is_req && tx_word.eop_or_dir;
	assign rx_sel_qid   = tx_word.data[QID_WIDTH-1:0];

	a_data_after_req: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		data_wr |-> tgt_valid)
		else $error("c2n data word with no target queue");

endmodule

`default_nettype wire

// ==== rtl/dma_rx_collect.sv ====
// receive collector; drains the requested queue onto the rx stream one packet at a time
`timescale 1ns/1ps
`default_nettype none

module dma_rx_collect #(
	parameter int NUM_CPU_QUEUES = 4
) (
	input  wire logic                             cpci_clk,
	input  wire logic                             cpci_reset,
	input  wire logic                             rx_sel_valid,
	input  wire logic [dma_queue_pkg::QID_WIDTH-1:0] rx_sel_qid,
	output logic [NUM_CPU_QUEUES-1:0]             q_rd,
	input  var  dma_queue_pkg::dma_rx_word_t      q_rd_word [NUM_CPU_QUEUES],
	input  wire logic [NUM_CPU_QUEUES-1:0]        q_empty,
	output dma_queue_pkg::dma_rx_word_t           rx_word,
	output logic                                  rx_valid,
	input  wire logic                             rx_ready
);
	import dma_queue_pkg::*;

	localparam logic [NUM_CPU_QUEUES-1:0] Q0_BIT = 1;

	logic [QID_WIDTH-1:0]      sel_qid;
	logic                      busy; // packet in flight
	logic [NUM_CPU_QUEUES-1:0] sel_mask;
	logic                      xfer;

	assign sel_mask = busy ? (Q0_BIT << sel_qid) : '0;
	assign rx_valid = |(sel_mask & ~q_empty);
	assign xfer     = rx_valid && rx_ready;
	assign q_rd     = xfer ? sel_mask : '0; // pop on handshake

	always_comb begin
		rx_word = '0;
		for (int i = 0; i < NUM_CPU_QUEUES; i++) begin
			if (sel_mask[i])
				rx_word = q_rd_word[i];
		end
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			busy    <= 1'b0;
			sel_qid <= '0;
		end else if (rx_sel_valid) begin
			busy    <= 1'b1;
			sel_qid <= rx_sel_qid;
		end else if (xfer && rx_word.eop) begin
			busy    <= 1'b0; // packet done
		end
	end

	// the FSM only asks again after the previous packet ended
	a_sel_not_busy: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		rx_sel_valid |-> !busy)
		else $error("rx request while a packet is still in flight");

endmodule

`default_nettype wire

// ==== rtl/dma_bus_fsm.sv ====
// bus FSM facing the CPCI chip; registers the pins, answers queries, moves c2n and n2c words
`timescale 1ns/1ps
`default_nettype none

module dma_bus_fsm #(
	parameter int NUM_CPU_QUEUES    = 4,
	parameter int PKT_LEN_CNT_WIDTH = 11
) (
	input  wire logic                                   cpci_clk,
	input  wire logic                                   cpci_reset,
	input  wire logic                                   enable_dma,
	// cpci pins
	input  var  dma_bus_pkg::dma_op_e                   dma_op_code_req,
	input  wire logic [dma_queue_pkg::QID_WIDTH-1:0]    dma_op_queue_id,
	output dma_bus_pkg::dma_op_e                        dma_op_code_ack,
	input  wire logic                                   dma_vld_c2n,
	input  wire logic [dma_bus_pkg::DMA_DATA_WIDTH-1:0] dma_data_c2n,
	output logic                                        dma_dest_q_nearly_full_n2c,
	output logic                                        dma_vld_n2c,
	output logic [dma_bus_pkg::DMA_DATA_WIDTH-1:0]      dma_data_n2c,
	input  wire logic                                   dma_dest_q_nearly_full_c2n,
	output logic                                        dma_data_tri_en,
	// transmit stream without handshake
	output dma_queue_pkg::dma_tx_word_t                 tx_word,
	output logic                                        tx_wr,
	input  wire logic                                   tx_nearly_full,
	// receive stream
	input  var  dma_queue_pkg::dma_rx_word_t            rx_word,
	input  wire logic                                   rx_valid,
	output logic                                        rx_ready,
	// queue flags for the status word
	input  wire logic [NUM_CPU_QUEUES-1:0]              pkt_avail,
	input  wire logic [NUM_CPU_QUEUES-1:0]              q_nearly_full
);
	import dma_bus_pkg::*;
	import dma_queue_pkg::*;

	localparam logic [PKT_LEN_CNT_WIDTH-1:0] WORD_BYTES = 4;

	// pins after the input register
	dma_op_e                      op_req_d;
	logic [QID_WIDTH-1:0]         qid_d;
	logic                         vld_c2n_d;
	logic [DMA_DATA_WIDTH-1:0]    data_c2n_d;
	logic                         nf_c2n_d; // host asks us to hold off

	dma_bus_state_e               state, state_nxt;
	dma_op_e                      ack_nxt;
	logic                         vld_n2c_nxt;
	logic                         tri_en_nxt;
	logic [DMA_DATA_WIDTH-1:0]    data_n2c_nxt;
	logic [DMA_DATA_WIDTH-1:0]    status_word;
	logic [PKT_LEN_CNT_WIDTH-1:0] tx_len, tx_len_nxt; // c2n bytes left
	logic [PKT_LEN_CNT_WIDTH-1:0] rx_len, rx_len_nxt; // n2c bytes left
	logic                         rx_xfer;

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			op_req_d  <= OP_IDLE;
			vld_c2n_d <= 1'b0;
			nf_c2n_d  <= 1'b0;
		end else begin
			op_req_d  <= dma_op_code_req;
			vld_c2n_d <= dma_vld_c2n;
			nf_c2n_d  <= dma_dest_q_nearly_full_c2n;
		end
	end

	always_ff @(posedge cpci_clk) begin // payload pins
		qid_d      <= dma_op_queue_id;
		data_c2n_d <= dma_data_c2n;
	end

	// pkt_avail from bit 16, nearly_full from bit 0
	always_comb begin
		status_word = '0;
		status_word[16 +: NUM_CPU_QUEUES] = pkt_avail;
		status_word[0 +: NUM_CPU_QUEUES]  = q_nearly_full;
	end

	assign rx_ready = (state == ST_N2C_LEN || state == ST_N2C_DATA) && !nf_c2n_d;
	assign rx_xfer  = rx_valid && rx_ready;

	//////////////////////////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt    = state;
		ack_nxt      = dma_op_code_ack;
		tri_en_nxt   = dma_data_tri_en;
		vld_n2c_nxt  = 1'b0;
		data_n2c_nxt = '0;
		tx_len_nxt   = tx_len;
		rx_len_nxt   = rx_len;
		tx_wr        = 1'b0;
		tx_word      = '0;

		case (state)
			ST_IDLE: begin
				if (enable_dma) begin
					case (op_req_d)
						OP_STATUS_QUERY: state_nxt = ST_QUERY;
						OP_TRANSF_C2N:   state_nxt = ST_C2N_QID;
						OP_TRANSF_N2C:   state_nxt = ST_N2C_QID;
						default:         state_nxt = ST_IDLE;
					endcase
				end
			end

			ST_QUERY: begin // status repeats every cycle until a transfer starts
				ack_nxt      = OP_STATUS_QUERY;
				tri_en_nxt   = 1'b1;
				vld_n2c_nxt  = 1'b1;
				data_n2c_nxt = status_word;
				if (op_req_d == OP_TRANSF_C2N)
					state_nxt = ST_C2N_QID;
				else if (op_req_d == OP_TRANSF_N2C)
					state_nxt = ST_N2C_QID;
			end

			ST_C2N_QID: begin
				ack_nxt        = OP_TRANSF_C2N;
				tri_en_nxt     = 1'b0; // host drives the data pins
				tx_wr          = 1'b1;
				tx_word.is_req = 1'b1; // eop_or_dir stays 0 for a tx request
				tx_word.data   = {{(DMA_DATA_WIDTH-QID_WIDTH){1'b0}}, qid_d};
				state_nxt      = ST_C2N_LEN;
			end

			ST_C2N_LEN: begin
				if (vld_c2n_d) begin
					tx_wr      = 1'b1;
					tx_word.data = data_c2n_d; // length word goes into the queue too
					tx_len_nxt = data_c2n_d[PKT_LEN_CNT_WIDTH-1:0];
					if (tx_len_nxt == '0) begin
						tx_word.eop_or_dir = 1'b1; // empty packet ends here
						state_nxt = ST_C2N_DONE;
					end else begin
						state_nxt = ST_C2N_DATA;
					end
				end
			end

			ST_C2N_DATA: begin
				if (vld_c2n_d) begin
					tx_wr        = 1'b1;
					tx_word.data = data_c2n_d;
					if (tx_len <= WORD_BYTES) begin // last word
						tx_word.eop_or_dir  = 1'b1;
						tx_word.valid_bytes = tx_len[1:0];
						tx_len_nxt = '0;
						state_nxt  = ST_C2N_DONE;
					end else begin
						tx_len_nxt = tx_len - WORD_BYTES;
					end
				end
			end

			ST_C2N_DONE: begin
				if (op_req_d == OP_STATUS_QUERY)
					state_nxt = ST_QUERY;
				else if (op_req_d == OP_TRANSF_N2C)
					state_nxt = ST_N2C_QID;
			end

			ST_N2C_QID: begin
				ack_nxt            = OP_TRANSF_N2C;
				tri_en_nxt         = 1'b1;
				tx_wr              = 1'b1;
				tx_word.is_req     = 1'b1;
				tx_word.eop_or_dir = 1'b1; // rx request
				tx_word.data       = {{(DMA_DATA_WIDTH-QID_WIDTH){1'b0}}, qid_d};
				rx_len_nxt         = '0;
				state_nxt          = ST_N2C_LEN;
			end

			ST_N2C_LEN: begin
				if (rx_xfer) begin
					vld_n2c_nxt  = 1'b1;
					data_n2c_nxt = rx_word.data;
					rx_len_nxt   = rx_word.data[PKT_LEN_CNT_WIDTH-1:0];
					state_nxt    = (rx_len_nxt == '0) ? ST_N2C_DONE : ST_N2C_DATA;
				end
			end

			ST_N2C_DATA: begin
				if (rx_xfer) begin
					vld_n2c_nxt  = 1'b1;
					data_n2c_nxt = rx_word.data;
					if (rx_len <= WORD_BYTES) begin
						rx_len_nxt = '0;
						state_nxt  = ST_N2C_DONE;
					end else begin
						rx_len_nxt = rx_len - WORD_BYTES;
					end
				end
			end

			ST_N2C_DONE: begin
				if (op_req_d == OP_STATUS_QUERY)
					state_nxt = ST_QUERY;
				else if (op_req_d == OP_TRANSF_C2N)
					state_nxt = ST_C2N_QID;
			end

			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			state                      <= ST_IDLE;
			dma_op_code_ack            <= OP_IDLE;
			dma_vld_n2c                <= 1'b0;
			dma_data_tri_en            <= 1'b0;
			dma_dest_q_nearly_full_n2c <= 1'b0;
			tx_len                     <= '0;
			rx_len                     <= '0;
		end else begin
			state                      <= state_nxt;
			dma_op_code_ack            <= ack_nxt;
			dma_vld_n2c                <= vld_n2c_nxt;
			dma_data_tri_en            <= tri_en_nxt;
			dma_dest_q_nearly_full_n2c <= tx_nearly_full; // selected queue to host
			tx_len                     <= tx_len_nxt;
			rx_len                     <= rx_len_nxt;
		end
	end

	always_ff @(posedge cpci_clk)
		dma_data_n2c <= data_n2c_nxt;

	// stored eop mark and length count end a packet on the same word
	a_rx_eop_at_len: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		rx_xfer && state == ST_N2C_DATA |-> rx_word.eop == (rx_len <= WORD_BYTES))
		else $error("n2c eop does not line up with the length count");

endmodule

`default_nettype wire

// ==== rtl/dma_top.sv ====
// DMA subsystem top; bus FSM, tx dispatcher, CPU queues and rx collector on cpci_clk
`timescale 1ns/1ps
`default_nettype none

module dma_top #(
	parameter int NUM_CPU_QUEUES    = 4, // at most 4, status word layout
	parameter int PKT_LEN_CNT_WIDTH = 11,
	parameter int QUEUE_DEPTH       = 64,
	parameter int NEARLY_FULL_FREE  = 16
) (
	input  wire logic                                   cpci_clk,
	input  wire logic                                   cpci_reset,
	input  wire logic                                   enable_dma,
	input  var  dma_bus_pkg::dma_op_e                   dma_op_code_req,
	input  wire logic [dma_queue_pkg::QID_WIDTH-1:0]    dma_op_queue_id,
	output dma_bus_pkg::dma_op_e                        dma_op_code_ack,
	input  wire logic                                   dma_vld_c2n,
	input  wire logic [dma_bus_pkg::DMA_DATA_WIDTH-1:0] dma_data_c2n,
	output logic                                        dma_dest_q_nearly_full_n2c,
	output logic                                        dma_vld_n2c,
	output logic [dma_bus_pkg::DMA_DATA_WIDTH-1:0]      dma_data_n2c,
	input  wire logic                                   dma_dest_q_nearly_full_c2n,
	output logic                                        dma_data_tri_en
);
	import dma_queue_pkg::*;

	dma_tx_word_t              tx_word;
	logic                      tx_wr, tx_nearly_full;
	dma_rx_word_t              rx_word;
	logic                      rx_valid, rx_ready;
	logic                      rx_sel_valid;
	logic [QID_WIDTH-1:0]      rx_sel_qid;
	dma_rx_word_t              q_wr_word;
	dma_rx_word_t              q_rd_word [NUM_CPU_QUEUES];
	logic [NUM_CPU_QUEUES-1:0] q_wr, q_rd, q_empty;
	logic [NUM_CPU_QUEUES-1:0] pkt_avail, q_nearly_full; // to status word

	dma_bus_fsm #(
		.NUM_CPU_QUEUES(NUM_CPU_QUEUES),
		.PKT_LEN_CNT_WIDTH(PKT_LEN_CNT_WIDTH)
	) u_bus_fsm (
		.cpci_clk, .cpci_reset, .enable_dma,
		.dma_op_code_req, .dma_op_queue_id, .dma_op_code_ack,
		.dma_vld_c2n, .dma_data_c2n, .dma_dest_q_nearly_full_n2c,
		.dma_vld_n2c, .dma_data_n2c, .dma_dest_q_nearly_full_c2n, .dma_data_tri_en,
		.tx_word, .tx_wr, .tx_nearly_full,
		.rx_word, .rx_valid, .rx_ready,
		.pkt_avail, .q_nearly_full
	);

	dma_tx_dispatch #(.NUM_CPU_QUEUES(NUM_CPU_QUEUES)) u_tx_dispatch (
		.cpci_clk, .cpci_reset, .tx_word, .tx_wr,
		.q_wr, .q_wr_word, .q_nearly_full, .tx_nearly_full,
		.rx_sel_valid, .rx_sel_qid
	);

	for (genvar i = 0; i < NUM_CPU_QUEUES; i++) begin : g_queue
		cpu_queue #(
			.QUEUE_DEPTH(QUEUE_DEPTH),
			.NEARLY_FULL_FREE(NEARLY_FULL_FREE)
		) u_queue (
			.cpci_clk, .cpci_reset,
			.wr(q_wr[i]), .wr_word(q_wr_word),
			.rd(q_rd[i]), .rd_word(q_rd_word[i]),
			.empty(q_empty[i]), .pkt_avail(pkt_avail[i]), .nearly_full(q_nearly_full[i])
		);
	end

	dma_rx_collect #(.NUM_CPU_QUEUES(NUM_CPU_QUEUES)) u_rx_collect (
		.cpci_clk, .cpci_reset, .rx_sel_valid, .rx_sel_qid,
		.q_rd, .q_rd_word, .q_empty,
		.rx_word, .rx_valid, .rx_ready
	);

endmodule

`default_nettype wire

// ==== tb/dma_clk_gen.sv ====
// testbench clock (100 ns period) and power-on reset for the DMA subsystem
`timescale 1ns/1ps
`default_nettype none

module dma_clk_gen #(
	parameter int HALF_PERIOD  = 50, // ns
	parameter int RESET_CYCLES = 8
) (
	output logic cpci_clk,
	output logic cpci_reset
);

	initial begin
		cpci_clk = 1'b0;
		forever #(HALF_PERIOD) cpci_clk = ~cpci_clk;
	end

	initial begin
		cpci_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge cpci_clk);
		@(negedge cpci_clk);
		cpci_reset = 1'b0; // released on a falling edge
	end

endmodule

`default_nettype wire

// ==== tb/dma_tb.sv ====
// self-checking testbench for dma_top; plays tb/dma_vectors.txt through a CPCI host bus model
`timescale 1ns/1ps
`default_nettype none

module dma_tb;
	import dma_bus_pkg::*;
	import dma_queue_pkg::*;

	localparam int NUM_Q          = 4;
	localparam int MAX_VEC        = 64;
	localparam int CYCLES_PER_VEC = 200;
	localparam int SETTLE_CYCLES  = 3; // quiet cycles after a transfer

	// command codes in the vector file
	localparam logic [3:0] CMD_QUERY  = 4'h0;
	localparam logic [3:0] CMD_C2N    = 4'h1;
	localparam logic [3:0] CMD_N2C    = 4'h2;
	localparam logic [3:0] CMD_EN_OFF = 4'h3;
	localparam logic [3:0] CMD_EN_ON  = 4'h4;
	localparam logic [3:0] CMD_END    = 4'hf;

	logic                      cpci_clk;
	logic                      cpci_reset;
	logic                      enable_dma;
	dma_op_e                   dma_op_code_req;
	logic [QID_WIDTH-1:0]      dma_op_queue_id;
	dma_op_e                   dma_op_code_ack;
	logic                      dma_vld_c2n;
	logic [DMA_DATA_WIDTH-1:0] dma_data_c2n;
	logic                      dma_dest_q_nearly_full_n2c;
	logic                      dma_vld_n2c;
	logic [DMA_DATA_WIDTH-1:0] dma_data_n2c;
	logic                      dma_dest_q_nearly_full_c2n;
	logic                      dma_data_tri_en;

	logic [55:0] vec_mem [MAX_VEC];  // {cmd, qid, len, expect}
	logic [31:0] ref_q [NUM_Q][$];   // per queue, length word then payload
	integer      seed;
	int          num_vec;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	dma_clk_gen u_clk_gen (.cpci_clk, .cpci_reset);

	dma_top dut (.*);

	//////////////////////////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	function automatic string mismatch_line(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		return $sformatf("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
	endfunction

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else abort_run(mismatch_line(what, got, exp));
	endtask

	// run limit, worked out once the vectors are loaded
	always @(posedge cpci_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
			abort_run($sformatf("timeout: run still going after %0d cycles", cycle_cnt));
	end

	//////////////////////////////////////////////////////////////////////
	// host bus model
	//////////////////////////////////////////////////////////////////////

	// park the FSM in the query state so any transfer can follow
	task automatic enter_query_state();
		dma_op_code_req = OP_STATUS_QUERY;
		do @(negedge cpci_clk);
		while (!(dma_vld_n2c && dma_op_code_ack == OP_STATUS_QUERY));
	endtask

	task automatic run_query(input logic [31:0] exp_status);
		dma_op_code_req = OP_STATUS_QUERY;
		if (!enable_dma) begin
			repeat (10) begin
				@(negedge cpci_clk);
				assert (!dma_vld_n2c && !dma_data_tri_en)
					else abort_run("bus answered a query while DMA was disabled");
			end
			dma_op_code_req = OP_IDLE;
			@(negedge cpci_clk);
		end else begin
			do @(negedge cpci_clk);
			while (!dma_vld_n2c);
			check_word("status ack", 32'(dma_op_code_ack), 32'(OP_STATUS_QUERY));
			assert (dma_data_tri_en) else abort_run("tri_en low while status is on the bus");
			check_word("status word", dma_data_n2c, exp_status);
		end
	endtask

	task automatic run_c2n(input logic [3:0] qid, input logic [15:0] len, input bit expect_nf);
		logic [31:0] word;
		int          n_words;
		bit          nf_seen;
		n_words = (int'(len) + 3) / 4;
		nf_seen = 1'b0;
		enter_query_state();
		dma_op_queue_id = qid;
		dma_op_code_req = OP_TRANSF_C2N;
		do @(negedge cpci_clk);
		while (dma_op_code_ack != OP_TRANSF_C2N); // FSM now waits for the length
		word = {16'h0, len};
		ref_q[qid].push_back(word);
		dma_vld_c2n  = 1'b1;
		dma_data_c2n = word;
		for (int i = 0; i < n_words; i++) begin
			@(negedge cpci_clk);
			nf_seen = nf_seen | dma_dest_q_nearly_full_n2c;
			word = $random(seed);
			ref_q[qid].push_back(word);
			dma_data_c2n = word;
		end
		@(negedge cpci_clk);
		dma_vld_c2n  = 1'b0;
		dma_data_c2n = '0;
		repeat (SETTLE_CYCLES) begin // last writes land two cycles later
			@(negedge cpci_clk);
			nf_seen = nf_seen | dma_dest_q_nearly_full_n2c;
		end
		if (expect_nf)
			assert (nf_seen) else abort_run("queue nearly-full pin never rose during c2n");
	endtask

	task automatic run_n2c(input logic [3:0] qid);
		logic [31:0] exp_len;
		logic [31:0] exp_word;
		int          words_left;
		int          after_rise; // n2c words seen since nearly full went up
		bit          got_len;
		bit          bp;
		bit          bp_next;
		assert (ref_q[qid].size() != 0)
			else abort_run($sformatf("n2c from queue %0d which holds no packet", qid));
		exp_len    = ref_q[qid].pop_front();
		words_left = (int'(exp_len[15:0]) + 3) / 4;
		got_len    = 1'b0;
		after_rise = 0;
		bp         = 1'b0;
		enter_query_state();
		dma_op_queue_id = qid;
		dma_op_code_req = OP_TRANSF_N2C;
		while (!got_len || words_left > 0) begin
			@(negedge cpci_clk);
			if (dma_vld_n2c && dma_op_code_ack == OP_TRANSF_N2C) begin
				if (!got_len) begin
					check_word("n2c length word", dma_data_n2c, exp_len);
					got_len = 1'b1;
				end else begin
					exp_word = ref_q[qid].pop_front();
					check_word("n2c payload word", dma_data_n2c, exp_word);
					words_left--;
				end
				if (bp)
					after_rise++;
			end
			assert (after_rise <= 2)
				else abort_run("more than two n2c words after host raised nearly full");
			// random back-pressure: raised one cycle in four, dropped with even odds
			if (bp)
				bp_next = (($random(seed) & 1) != 0);
			else
				bp_next = (($random(seed) & 3) == 0);
			if (bp_next && !bp)
				after_rise = 0;
			bp = bp_next;
			dma_dest_q_nearly_full_c2n = bp;
		end
		dma_dest_q_nearly_full_c2n = 1'b0;
		repeat (SETTLE_CYCLES) begin
			@(negedge cpci_clk);
			assert (!dma_vld_n2c) else abort_run("n2c sent more words than its length announced");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [3:0]  cmd;
		logic [3:0]  qid;
		logic [15:0] len;
		logic [31:0] exp_val;
		seed                       = 93691;
		enable_dma                 = 1'b0;
		dma_op_code_req            = OP_IDLE;
		dma_op_queue_id            = '0;
		dma_vld_c2n                = 1'b0;
		dma_data_c2n               = '0;
		dma_dest_q_nearly_full_c2n = 1'b0;

		for (int i = 0; i < MAX_VEC; i++)
			vec_mem[i] = '1; // unread lines look like the end marker
		$readmemh("tb/dma_vectors.txt", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC && vec_mem[num_vec][55:52] != CMD_END)
			num_vec++;
		cycle_limit = CYCLES_PER_VEC * num_vec + 50;

		@(negedge cpci_reset);
		@(negedge cpci_clk);
		assert (dma_op_code_ack == OP_IDLE && !dma_vld_n2c && !dma_data_tri_en
			&& !dma_dest_q_nearly_full_n2c)
			else abort_run("bus outputs not idle after reset");

		for (int v = 0; v < num_vec; v++) begin
			{cmd, qid, len, exp_val} = vec_mem[v];
			case (cmd)
				CMD_QUERY: run_query(exp_val);
				CMD_C2N:   run_c2n(qid, len, exp_val != 0);
				CMD_N2C:   run_n2c(qid);
				CMD_EN_OFF: begin
					enable_dma = 1'b0;
					@(negedge cpci_clk);
				end
				CMD_EN_ON: begin
					enable_dma = 1'b1;
					@(negedge cpci_clk);
				end
				default: abort_run($sformatf("unknown command %h on vector %0d", cmd, v));
			endcase
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/dma_vectors.txt ====
// one hex word per line: cmd _ qid _ byte length _ expected value
// cmd 0 query (expect status), 1 c2n (expect 1 if nearly-full pin must rise), 2 n2c, 3 off, 4 on, f end
3_0_0000_00000000
0_0_0000_00000000
4_0_0000_00000000
0_0_0000_00000000
// two packets, queue 3 gets an empty one
1_1_000d_00000000
1_3_0000_00000000
0_0_0000_000a0000
1_3_0008_00000000
0_0_0000_000a0000
// drain queue 1, then both packets of queue 3
2_1_0000_00000000
0_0_0000_00080000
2_3_0000_00000000
0_0_0000_00080000
2_3_0000_00000000
0_0_0000_00000000
// 200 bytes fill queue 2 past the nearly-full mark
1_2_00c8_00000001
0_0_0000_00040004
2_2_0000_00000000
0_0_0000_00000000
// two packets in queue 0, read back one at a time
1_0_001f_00000000
1_0_0005_00000000
0_0_0000_00010000
2_0_0000_00000000
2_0_0000_00000000
0_0_0000_00000000
f_0_0000_00000000

// ==== filelist.f ====
rtl/dma_bus_pkg.sv
rtl/dma_queue_pkg.sv
rtl/cpu_queue.sv
rtl/dma_tx_dispatch.sv
rtl/dma_rx_collect.sv
rtl/dma_bus_fsm.sv
rtl/dma_top.sv
tb/dma_clk_gen.sv
tb/dma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the DMA testbench with Verilator; run from anywhere
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module dma_tb -o dma_sim
./obj_dir/dma_sim 2>&1 | tee sim.log
if grep -q "Done: errors found" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"
